// File: dmux_pkg.sv
/*
 * shared widths, enums and structs for the receive demultiplexer
 * the register map is fixed at three DMA channels
 */
package dmux_pkg;

   // ------------------------------------------------
   // widths
   // ------------------------------------------------
   localparam int num_ch     = 3;
   localparam int data_w     = 32;
   localparam int keep_w     = data_w / 8;
   localparam int meta_w     = 8;
   localparam int thresh_w   = 16;
   localparam int csr_addr_w = 4;
   localparam int csr_data_w = 32;

   // ------------------------------------------------
   // enums
   // ------------------------------------------------
   // channel ports first so the value doubles as channel index
   typedef enum logic [2:0] {
      port_dma0 = 3'd0,
      port_dma1 = 3'd1,
      port_dma2 = 3'd2,
      port_eth  = 3'd3,
      port_host = 3'd4
   } port_e;

   typedef enum logic [csr_addr_w-1:0] {
      csr_drop_en  = 4'd0,
      csr_thresh_0 = 4'd1,
      csr_thresh_1 = 4'd2,
      csr_thresh_2 = 4'd3
   } csr_reg_e;

   // ------------------------------------------------
   // structs
   // ------------------------------------------------
   // destination of one ingress beat
   typedef struct packed {
      port_e             egr_port;
      logic              mcast_en;
      logic [num_ch-1:0] mcast_mask;
   } seg_info_t;

   // one stored beat, last already resolved per channel
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [keep_w-1:0] keep;
      logic [meta_w-1:0] meta;
      logic              last;
   } beat_t;

   // overload rule of one channel
   typedef struct packed {
      logic                drop_en;
      logic [thresh_w-1:0] thresh;
   } ch_cfg_t;

endpackage

// File: dmux_beat_if.sv
/*
 * one ingress beat on its way from the router into the FIFO bank
 * last and write are per channel since truncation touches one channel only
 */
interface dmux_beat_if;
   import dmux_pkg::*;

   logic [data_w-1:0] data;
   logic [keep_w-1:0] keep;
   logic [meta_w-1:0] meta;
   // per-channel end of packet
   logic [num_ch-1:0] last;
   // per-channel write strobe
   logic [num_ch-1:0] wr;

   modport route (
      output data,
      output keep,
      output meta,
      output last,
      output wr
   );

   modport fifo (
      input data,
      input keep,
      input meta,
      input last,
      input wr
   );

endinterface

// File: dmux_csr.sv
/*
 * drop enable mask and per-channel thresholds, read data one cycle after the strobe
 * no byte enables, unmapped addresses read zero and ignore writes
 */
module dmux_csr (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic [dmux_pkg::csr_addr_w-1:0]            csr_addr,
   input  logic                                       csr_read,
   input  logic                                       csr_write,
   input  logic [dmux_pkg::csr_data_w-1:0]            csr_wdata,
   output logic [dmux_pkg::csr_data_w-1:0]            csr_rdata,
   output logic                                       csr_rvalid,
   output dmux_pkg::ch_cfg_t [dmux_pkg::num_ch-1:0]   cfg
);
   import dmux_pkg::*;

   csr_reg_e                  reg_sel;
   ch_cfg_t [num_ch-1:0]      cfg_q;
   logic [csr_data_w-1:0]     rd_next;

   assign reg_sel = csr_reg_e'(csr_addr);
   assign cfg     = cfg_q;

   // ------------------------------------------------
   // write side
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_q <= '0;
      end else if (csr_write) begin
         case (reg_sel)
            csr_drop_en: begin
               for (int i = 0; i < num_ch; i++) begin
                  cfg_q[i].drop_en <= csr_wdata[i];
               end
            end
            csr_thresh_0: cfg_q[0].thresh <= csr_wdata[thresh_w-1:0];
            csr_thresh_1: cfg_q[1].thresh <= csr_wdata[thresh_w-1:0];
            csr_thresh_2: cfg_q[2].thresh <= csr_wdata[thresh_w-1:0];
            default: ;
         endcase
      end
   end

   // ------------------------------------------------
   // read side
   // ------------------------------------------------
   always_comb begin
      rd_next = '0;
      case (reg_sel)
         csr_drop_en: begin
            for (int i = 0; i < num_ch; i++) begin
               rd_next[i] = cfg_q[i].drop_en;
            end
         end
         csr_thresh_0: rd_next[thresh_w-1:0] = cfg_q[0].thresh;
         csr_thresh_1: rd_next[thresh_w-1:0] = cfg_q[1].thresh;
         csr_thresh_2: rd_next[thresh_w-1:0] = cfg_q[2].thresh;
         default: ;
      endcase
   end

   // read data captured on the strobe
   always_ff @(posedge clk) begin
      if (csr_read) begin
         csr_rdata <= rd_next;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_read;
      end
   end

   // the host side must serialize its accesses
   a_no_rd_wr : assert property (@(posedge clk) disable iff (rst)
      !(csr_read && csr_write));

endmodule

// File: dmux_egr_fifo.sv
/*
 * single-clock egress FIFO for one channel, head shown while not empty
 * depth must be a power of two, ingress back-pressure keeps writes away from a full FIFO
 */
module dmux_egr_fifo #(
   parameter int depth = 16,
   parameter int ch    = 0
) (
   input  logic                                 clk,
   input  logic                                 rst,
   dmux_beat_if.fifo                            beat,
   output logic [$clog2(depth+1)-1:0]           occupancy,
   output logic                                 out_valid,
   output logic [dmux_pkg::data_w-1:0]          out_data,
   output logic [dmux_pkg::keep_w-1:0]          out_keep,
   output logic                                 out_last,
   output logic [dmux_pkg::meta_w-1:0]          out_meta,
   input  logic                                 out_ready
);
   import dmux_pkg::*;

   localparam int aw = $clog2(depth);

   beat_t          mem [depth];
   beat_t          head;
   logic [aw-1:0]  wr_ptr;
   logic [aw-1:0]  rd_ptr;
   logic           wr_en;
   logic           rd_en;

   assign wr_en = beat.wr[ch];
   assign rd_en = out_valid && out_ready;

   // storage, payload only
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= '{data: beat.data,
                          keep: beat.keep,
                          meta: beat.meta,
                          last: beat.last[ch]};
      end
   end

   // ------------------------------------------------
   // pointers and fill level
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         occupancy <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // read and write together leave the count alone
         case ({wr_en, rd_en})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: ;
         endcase
      end
   end

   // show-ahead output
   assign head      = mem[rd_ptr];
   assign out_valid = (occupancy != '0);
   assign out_data  = head.data;
   assign out_keep  = head.keep;
   assign out_meta  = head.meta;
   assign out_last  = head.last;

   // in_ready at the top must stall ingress before the FIFO fills
   a_no_wr_full : assert property (@(posedge clk) disable iff (rst)
      wr_en |-> (occupancy < depth));

endmodule

// File: dmux_route.sv
/*
 * per-channel targeting, threshold truncation and drop pulses
 * drop enable should stay stable while a packet is in flight
 */
module dmux_route #(
   parameter int depth = 16
) (
   input  logic                                                    clk,
   input  logic                                                    rst,
   input  logic                                                    in_valid,
   input  logic                                                    in_ready,
   input  logic [dmux_pkg::data_w-1:0]                             in_data,
   input  logic [dmux_pkg::keep_w-1:0]                             in_keep,
   input  logic                                                    in_last,
   input  logic [dmux_pkg::meta_w-1:0]                             in_meta,
   input  dmux_pkg::seg_info_t                                     seg,
   input  dmux_pkg::ch_cfg_t [dmux_pkg::num_ch-1:0]                cfg,
   input  logic [dmux_pkg::num_ch-1:0][$clog2(depth+1)-1:0]        occupancy,
   dmux_beat_if.route                                              beat,
   output logic [dmux_pkg::num_ch-1:0]                             drop_pulse
);
   import dmux_pkg::*;

   logic                accept;
   logic [num_ch-1:0]   target;
   logic [num_ch-1:0]   over;
   logic [num_ch-1:0]   trunc;
   // rest of the current packet is thrown away for this channel
   logic [num_ch-1:0]   discard;

   assign accept = in_valid && in_ready;

   // payload is shared by every channel
   assign beat.data = in_data;
   assign beat.keep = in_keep;
   assign beat.meta = in_meta;

   // ------------------------------------------------
   // per-channel decision
   // ------------------------------------------------
   for (genvar i = 0; i < num_ch; i++) begin : g_ch
      // mask wins over the unicast port when multicast is on
      assign target[i] = seg.mcast_en ? seg.mcast_mask[i]
                                      : (seg.egr_port == port_e'(i));

      // occupancy before this write, last beats never truncate
      assign over[i] = cfg[i].drop_en && !in_last &&
                       (thresh_w'(occupancy[i]) > cfg[i].thresh);

      assign trunc[i]     = accept && target[i] && !discard[i] && over[i];
      assign beat.wr[i]   = accept && target[i] && !discard[i];
      assign beat.last[i] = in_last || trunc[i];

      always_ff @(posedge clk) begin
         if (rst) begin
            discard[i] <= 1'b0;
         end else if (trunc[i]) begin
            discard[i] <= 1'b1;
         end else if (accept && in_last) begin
            discard[i] <= 1'b0;
         end
      end

      // one pulse after the final beat of a truncated packet
      always_ff @(posedge clk) begin
         if (rst) begin
            drop_pulse[i] <= 1'b0;
         end else begin
            drop_pulse[i] <= accept && in_last && discard[i];
         end
      end

      a_pulse_needs_en : assert property (@(posedge clk) disable iff (rst)
         $rose(drop_pulse[i]) |-> cfg[i].drop_en);
   end

endmodule

// File: dma_rx_dmux.sv
/*
 * receive demultiplexer, packet bridge ingress to three message-DMA channels
 * fifo_depth must be a power of two and ready_margin at least 2
 */
module dma_rx_dmux #(
   parameter int fifo_depth   = 16,
   parameter int ready_margin = 4
) (
   input  logic                                                   clk,
   input  logic                                                   rst,

   // ingress stream
   input  logic                                                   in_valid,
   input  logic [dmux_pkg::data_w-1:0]                            in_data,
   input  logic [dmux_pkg::keep_w-1:0]                            in_keep,
   input  logic                                                   in_last,
   input  logic [dmux_pkg::meta_w-1:0]                            in_meta,
   input  dmux_pkg::port_e                                        in_port,
   input  logic                                                   in_mcast_en,
   input  logic [dmux_pkg::num_ch-1:0]                            in_mcast_mask,
   output logic                                                   in_ready,

   // DMA channel streams
   output logic [dmux_pkg::num_ch-1:0]                            dma_valid,
   output logic [dmux_pkg::num_ch-1:0][dmux_pkg::data_w-1:0]      dma_data,
   output logic [dmux_pkg::num_ch-1:0][dmux_pkg::keep_w-1:0]      dma_keep,
   output logic [dmux_pkg::num_ch-1:0]                            dma_last,
   output logic [dmux_pkg::num_ch-1:0][dmux_pkg::meta_w-1:0]      dma_meta,
   input  logic [dmux_pkg::num_ch-1:0]                            dma_ready,

   // register port
   input  logic [dmux_pkg::csr_addr_w-1:0]                        csr_addr,
   input  logic                                                   csr_read,
   input  logic                                                   csr_write,
   input  logic [dmux_pkg::csr_data_w-1:0]                        csr_wdata,
   output logic [dmux_pkg::csr_data_w-1:0]                        csr_rdata,
   output logic                                                   csr_rvalid,

   output logic [dmux_pkg::num_ch-1:0]                            drop_pulse
);
   import dmux_pkg::*;

   localparam int occ_w = $clog2(fifo_depth + 1);

   seg_info_t                        seg;
   ch_cfg_t [num_ch-1:0]             cfg;
   logic [num_ch-1:0][occ_w-1:0]     occ;
   logic [num_ch-1:0]                room;

   dmux_beat_if beat_bus ();

   assign seg = '{egr_port:   in_port,
                  mcast_en:   in_mcast_en,
                  mcast_mask: in_mcast_mask};

   // ------------------------------------------------
   // ingress back-pressure
   // ------------------------------------------------
   always_comb begin
      for (int i = 0; i < num_ch; i++) begin
         room[i] = (occ[i] < occ_w'(fifo_depth - ready_margin));
      end
   end

   // registered, margin absorbs the beat already in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         in_ready <= 1'b0;
      end else begin
         in_ready <= &room;
      end
   end

   dmux_route #(
      .depth (fifo_depth)
   ) u_route (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_data    (in_data),
      .in_keep    (in_keep),
      .in_last    (in_last),
      .in_meta    (in_meta),
      .seg        (seg),
      .cfg        (cfg),
      .occupancy  (occ),
      .beat       (beat_bus.route),
      .drop_pulse (drop_pulse)
   );

   dmux_csr u_csr (
      .clk        (clk),
      .rst        (rst),
      .csr_addr   (csr_addr),
      .csr_read   (csr_read),
      .csr_write  (csr_write),
      .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .cfg        (cfg)
   );

   // ------------------------------------------------
   // one egress FIFO per channel
   // ------------------------------------------------
   for (genvar i = 0; i < num_ch; i++) begin : g_fifo
      dmux_egr_fifo #(
         .depth (fifo_depth),
         .ch    (i)
      ) u_fifo (
         .clk       (clk),
         .rst       (rst),
         .beat      (beat_bus.fifo),
         .occupancy (occ[i]),
         .out_valid (dma_valid[i]),
         .out_data  (dma_data[i]),
         .out_keep  (dma_keep[i]),
         .out_last  (dma_last[i]),
         .out_meta  (dma_meta[i]),
         .out_ready (dma_ready[i])
      );
   end

endmodule

// File: tb_clk_gen.sv
/* free-running clock, reset held high for the first rst_cycles rising edges */
module tb_clk_gen #(
   parameter int period     = 40,
   parameter int rst_cycles = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // released just after an edge, like every other stimulus
   initial begin
      rst = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      #2 rst = 1'b0;
   end

endmodule

// File: tb_dma_rx_dmux.sv
/*
 * testbench for the receive demultiplexer with fifo depth 16 and ready margin 4
 * a queue per channel predicts egress beats, in_ready and drop_pulse from the routing rules
 */
module tb_dma_rx_dmux;
   import dmux_pkg::*;

   localparam int depth  = 16;
   localparam int margin = 4;
   localparam int beat_w = data_w + keep_w + meta_w + 1;
   localparam int limit  = 400;

   logic                              clk;
   logic                              rst;
   logic                              in_valid;
   logic [data_w-1:0]                 in_data;
   logic [keep_w-1:0]                 in_keep;
   logic                              in_last;
   logic [meta_w-1:0]                 in_meta;
   port_e                             in_port;
   logic                              in_mcast_en;
   logic [num_ch-1:0]                 in_mcast_mask;
   logic                              in_ready;
   logic [num_ch-1:0]                 dma_valid;
   logic [num_ch-1:0][data_w-1:0]     dma_data;
   logic [num_ch-1:0][keep_w-1:0]     dma_keep;
   logic [num_ch-1:0]                 dma_last;
   logic [num_ch-1:0][meta_w-1:0]     dma_meta;
   logic [num_ch-1:0]                 dma_ready;
   logic [csr_addr_w-1:0]             csr_addr;
   logic                              csr_read;
   logic                              csr_write;
   logic [csr_data_w-1:0]             csr_wdata;
   logic [csr_data_w-1:0]             csr_rdata;
   logic                              csr_rvalid;
   logic [num_ch-1:0]                 drop_pulse;

   // reference model, beat packed as {data, keep, meta, last}
   logic [beat_w-1:0]   exp_q [num_ch][$];
   logic [num_ch-1:0]   disc_m;
   logic [num_ch-1:0]   exp_pulse;
   logic                exp_ready;
   logic [num_ch-1:0]   drop_en_m;
   logic [thresh_w-1:0] thr_m [num_ch];
   int                  rx_cnt [num_ch];
   int                  pulse_cnt [num_ch];

   logic [num_ch-1:0]   hold;
   logic                rand_rdy;
   logic [31:0]         data_lfsr;
   logic [31:0]         rdy_lfsr;
   int                  errors;
   int                  tests_run;
   int                  tests_failed;

   tb_clk_gen #(.period(40), .rst_cycles(4)) u_clk (.clk(clk), .rst(rst));

   dma_rx_dmux #(.fifo_depth(depth), .ready_margin(margin)) UUT (.*);

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         data_lfsr = lfsr_next(data_lfsr);
         v = {v[30:0], data_lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_val(input string name, input int idx, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Error at %0t: %s[%0d] = %h, expected %h", $time, name, idx, got, exp);
      end
   endtask

   task automatic report_fail(input string what);
      errors++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   a_rvalid_after_read : assert property (@(posedge clk) disable iff (rst)
      csr_read |=> csr_rvalid) else report_fail("csr_rvalid missing after a read");
   a_rvalid_only_read : assert property (@(posedge clk) disable iff (rst)
      !csr_read |=> !csr_rvalid) else report_fail("csr_rvalid high without a read");

   // egress ready, random or held low per channel
   always @(posedge clk) begin
      #2;
      for (int c = 0; c < num_ch; c++) begin
         rdy_lfsr = lfsr_next(rdy_lfsr);
         dma_ready[c] = !hold[c] && (!rand_rdy || rdy_lfsr[0]);
      end
   end

   // --------------------------------------------------
   // model and checks, mid-cycle where all is stable
   // --------------------------------------------------
   always @(negedge clk) begin
      logic [beat_w-1:0] b;
      logic              acc;
      logic              wr;
      logic              trunc;
      int                occ;
      if (rst !== 1'b0) begin
         for (int c = 0; c < num_ch; c++) begin
            exp_q[c].delete();
         end
         disc_m    = '0;
         exp_pulse = '0;
         exp_ready = 1'b0;
      end else begin
         check_val("in_ready", 0, 32'(in_ready), 32'(exp_ready));
         exp_ready = 1'b1;
         acc = in_valid && in_ready;
         for (int c = 0; c < num_ch; c++) begin
            occ = exp_q[c].size();
            check_val("dma_valid", c, 32'(dma_valid[c]), 32'(occ != 0));
            check_val("drop_pulse", c, 32'(drop_pulse[c]), 32'(exp_pulse[c]));
            if (drop_pulse[c]) begin
               pulse_cnt[c]++;
            end
            if (occ >= depth - margin) begin
               exp_ready = 1'b0;
            end
            if (dma_valid[c] && dma_ready[c] && occ != 0) begin
               b = exp_q[c].pop_front();
               rx_cnt[c]++;
               check_val("dma_data", c, dma_data[c], b[beat_w-1 -: data_w]);
               check_val("dma_keep", c, 32'(dma_keep[c]), 32'(b[meta_w+keep_w:meta_w+1]));
               check_val("dma_meta", c, 32'(dma_meta[c]), 32'(b[meta_w:1]));
               check_val("dma_last", c, 32'(dma_last[c]), 32'(b[0]));
            end
            // mask overrides the unicast port
            wr = acc && !disc_m[c] &&
                 (in_mcast_en ? in_mcast_mask[c] : (in_port == port_e'(c)));
            trunc = wr && drop_en_m[c] && !in_last && (occ > int'(thr_m[c]));
            exp_pulse[c] = acc && in_last && disc_m[c];
            if (wr) begin
               exp_q[c].push_back({in_data, in_keep, in_meta, in_last || trunc});
            end
            if (trunc) begin
               disc_m[c] = 1'b1;
            end else if (acc && in_last) begin
               disc_m[c] = 1'b0;
            end
         end
      end
   end

   // --------------------------------------------------
   // stimulus tasks, all start and end at posedge + 2
   // --------------------------------------------------
   task automatic send_beat(input logic last, input port_e port, input logic mc_en,
                            input logic [num_ch-1:0] mask);
      logic taken;
      int   t;
      in_valid      = 1'b1;
      in_data       = rand_bits(data_w);
      in_keep       = keep_w'(rand_bits(keep_w));
      in_meta       = meta_w'(rand_bits(meta_w));
      in_last       = last;
      in_port       = port;
      in_mcast_en   = mc_en;
      in_mcast_mask = mask;
      taken = 1'b0;
      t = 0;
      while (!taken && t < limit) begin
         @(negedge clk);
         taken = in_ready;
         @(posedge clk);
         #2;
         t++;
      end
      in_valid = 1'b0;
      in_last  = 1'b0;
      if (!taken) begin
         report_fail("ingress beat was never accepted");
      end
   endtask

   task automatic send_packet(input int len, input port_e port, input logic mc_en,
                              input logic [num_ch-1:0] mask);
      for (int i = 0; i < len; i++) begin
         send_beat(i == len - 1, port, mc_en, mask);
      end
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0 && t < limit) begin
         @(posedge clk);
         #2;
         t++;
      end
      if (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
         report_fail("egress channels did not drain");
      end
   endtask

   task automatic csr_wr(input logic [csr_addr_w-1:0] addr, input logic [31:0] data);
      csr_addr  = addr;
      csr_wdata = data;
      csr_write = 1'b1;
      @(posedge clk);
      #2;
      csr_write = 1'b0;
      case (addr)
         csr_drop_en:  drop_en_m = data[num_ch-1:0];
         csr_thresh_0: thr_m[0] = data[thresh_w-1:0];
         csr_thresh_1: thr_m[1] = data[thresh_w-1:0];
         csr_thresh_2: thr_m[2] = data[thresh_w-1:0];
         default: ;
      endcase
   endtask

   task automatic csr_rd(input logic [csr_addr_w-1:0] addr, input logic [31:0] exp);
      logic got;
      int   t;
      csr_addr = addr;
      csr_read = 1'b1;
      @(posedge clk);
      #2;
      csr_read = 1'b0;
      got = 1'b0;
      t = 0;
      while (!got && t < 8) begin
         @(negedge clk);
         got = csr_rvalid;
         t++;
      end
      if (!got) begin
         report_fail("no csr_rvalid after a register read");
      end else begin
         check_val("csr_rdata", int'(addr), csr_rdata, exp);
      end
      @(posedge clk);
      #2;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests_run++;
      if (errors != err_before) begin
         tests_failed++;
         $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_before);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      int e;
      int t;
      int rx0 [num_ch];
      int pc0 [num_ch];
      data_lfsr = 32'h234b_a788;
      rdy_lfsr  = 32'h234b_a788;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      in_valid = 1'b0;
      in_data = '0;
      in_keep = '0;
      in_last = 1'b0;
      in_meta = '0;
      in_port = port_eth;
      in_mcast_en = 1'b0;
      in_mcast_mask = '0;
      csr_addr = '0;
      csr_read = 1'b0;
      csr_write = 1'b0;
      csr_wdata = '0;
      hold = '0;
      rand_rdy = 1'b0;
      dma_ready = '1;
      drop_en_m = '0;
      for (int c = 0; c < num_ch; c++) begin
         thr_m[c] = '0;
         rx_cnt[c] = 0;
         pulse_cnt[c] = 0;
      end

      e = errors;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (rst !== 1'b0 && t < limit);
      check_val("csr_rvalid", 0, 32'(csr_rvalid), 32'(0));
      check_val("dma_valid", 0, 32'(dma_valid), 32'(0));
      check_val("drop_pulse", 0, 32'(drop_pulse), 32'(0));
      t = 0;
      while (!in_ready && t < limit) begin
         @(negedge clk);
         t++;
      end
      if (!in_ready) begin
         report_fail("in_ready did not rise after reset");
      end
      @(posedge clk);
      #2;
      for (int a = 0; a < 4; a++) begin
         csr_rd(csr_addr_w'(a), 32'h0);
      end
      finish_test("reset state", e);

      e = errors;
      csr_wr(csr_drop_en, 32'hffff_fff5);
      csr_wr(csr_thresh_0, 32'hdead_0011);
      csr_wr(csr_thresh_1, 32'h1234_5678);
      csr_wr(csr_thresh_2, 32'h0001_ffff);
      csr_rd(csr_drop_en, 32'h0000_0005);
      csr_rd(csr_thresh_0, 32'h0000_0011);
      csr_rd(csr_thresh_1, 32'h0000_5678);
      csr_rd(csr_thresh_2, 32'h0000_ffff);
      csr_wr(4'hc, 32'hffff_ffff);
      csr_rd(4'hc, 32'h0);
      csr_wr(csr_drop_en, 32'h0);
      finish_test("register access", e);

      e = errors;
      rand_rdy = 1'b1;
      for (int k = 0; k < 10; k++) begin
         send_packet(1 + int'(rand_bits(3)), port_e'(k % 5), 1'b0, '0);
      end
      wait_drain();
      finish_test("unicast routing", e);

      e = errors;
      for (int m = 0; m < 8; m++) begin
         send_packet(1 + int'(rand_bits(2)), port_host, 1'b1, num_ch'(m));
      end
      wait_drain();
      finish_test("multicast copies", e);

      // channel 1 stalled until ingress back-pressure holds
      e = errors;
      rand_rdy = 1'b0;
      hold = 3'b010;
      rx0 = rx_cnt;
      fork
         send_packet(20, port_dma1, 1'b0, '0);
         begin
            t = 0;
            while (in_ready && t < limit) begin
               @(negedge clk);
               t++;
            end
            if (in_ready) begin
               report_fail("in_ready never fell with channel 1 stalled");
            end
            repeat (6) @(negedge clk);
            hold = '0;
         end
      join
      wait_drain();
      check_val("channel beats", 1, 32'(rx_cnt[1] - rx0[1]), 32'(20));
      finish_test("back-pressure", e);

      // threshold 3, so the fifth beat is cut with last
      e = errors;
      hold = 3'b100;
      csr_wr(csr_thresh_2, 32'd3);
      csr_wr(csr_drop_en, 32'h4);
      rx0 = rx_cnt;
      pc0 = pulse_cnt;
      send_packet(10, port_eth, 1'b1, 3'b111);
      hold = '0;
      wait_drain();
      check_val("channel beats", 0, 32'(rx_cnt[0] - rx0[0]), 32'(10));
      check_val("channel beats", 1, 32'(rx_cnt[1] - rx0[1]), 32'(10));
      check_val("channel beats", 2, 32'(rx_cnt[2] - rx0[2]), 32'(5));
      for (int c = 0; c < num_ch; c++) begin
         check_val("drop pulses", c, 32'(pulse_cnt[c] - pc0[c]), 32'(c == 2));
      end
      csr_wr(csr_drop_en, 32'h0);
      finish_test("threshold truncation", e);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: tb.f
dmux_pkg.sv
dmux_beat_if.sv
dmux_csr.sv
dmux_egr_fifo.sv
dmux_route.sv
dma_rx_dmux.sv
tb_clk_gen.sv
tb_dma_rx_dmux.sv

// File: Makefile
# Verilator build and run of the receive demultiplexer testbench

BIN  := obj_dir/Vtb_dma_rx_dmux
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(BIN): tb.f $(SRCS)
	verilator --binary --assert --top-module tb_dma_rx_dmux -f tb.f -o Vtb_dma_rx_dmux

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
